// ==== rtl/trap_pkg.sv ====
// Shared CSR addresses, privilege and cause types for the machine-mode trap unit.
package trap_pkg;

    // Data word width.
    localparam int xlen = 32;

    // CSR address, as encoded in the instruction.
    typedef logic [11:0] csr_addr_t;
    // Privilege mode encoding.
    typedef logic [1:0] priv_t;
    // Trap or interrupt number.
    typedef logic [4:0] cause_t;

    // Machine trap setup.
    localparam csr_addr_t csr_mstatus    = 12'h300;
    localparam csr_addr_t csr_misa       = 12'h301;
    localparam csr_addr_t csr_medeleg    = 12'h302;
    localparam csr_addr_t csr_mideleg    = 12'h303;
    localparam csr_addr_t csr_mie        = 12'h304;
    localparam csr_addr_t csr_mtvec      = 12'h305;
    localparam csr_addr_t csr_mstatush   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t csr_mscratch   = 12'h340;
    localparam csr_addr_t csr_mepc       = 12'h341;
    localparam csr_addr_t csr_mcause     = 12'h342;
    localparam csr_addr_t csr_mtval      = 12'h343;
    localparam csr_addr_t csr_mip        = 12'h344;
    // Machine information registers, all read-only.
    localparam csr_addr_t csr_mvendorid  = 12'hf11;
    localparam csr_addr_t csr_marchid    = 12'hf12;
    localparam csr_addr_t csr_mimpid     = 12'hf13;
    localparam csr_addr_t csr_mhartid    = 12'hf14;
    localparam csr_addr_t csr_mconfigptr = 12'hf15;

    // Privilege levels in use.
    localparam priv_t priv_m = 2'd3;
    localparam priv_t priv_u = 2'd0;

    // External interrupt range.
    localparam int irq_first = 16;
    localparam int irq_last  = 31;

    // MXL=1, extensions I, M, A and C.
    localparam logic [xlen-1:0] misa_value    = 32'h4000_1105;
    // Architecture ID.
    localparam logic [xlen-1:0] marchid_value = 32'd37;
    // Major version 2 in bits 15:8.
    localparam logic [xlen-1:0] mimpid_value  = 32'h0000_0200;

    // The mstatus fields kept by this core.
    typedef struct packed {
        logic [18:0] rsv_hi;
        priv_t       mpp;
        logic [2:0]  rsv_mid;
        logic        mpie;
        logic [2:0]  rsv_low;
        logic        mie;
        logic [2:0]  rsv_base;
    } mstatus_fields_t;

    // The mcause layout.
    typedef struct packed {
        logic        irq;
        logic [25:0] rsv;
        cause_t      code;
    } mcause_fields_t;

    // One CSR word, seen raw or as mstatus or mcause.
    typedef union packed {
        logic [xlen-1:0] raw;
        mstatus_fields_t status;
        mcause_fields_t  cause;
    } csr_word_u;

endpackage

// ==== rtl/trap_if.sv ====
// Trap entry, trap return and interrupt mask signals shared by the dispatch, prioritizer and CSRs.
`timescale 1ns/1ns

interface trap_if;
    // Interrupt entry strobe.
    logic              ex_irq;
    // Synchronous trap entry strobe.
    logic              ex_trap;
    // Cause of the entry.
    trap_pkg::cause_t  ex_cause;
    // PC of the retiring instruction.
    logic [31:1]       ex_epc;
    // Privilege at trap time.
    trap_pkg::priv_t   ex_pp;
    // MRET strobe.
    logic              ret;
    // Return address from mepc.
    logic [31:1]       ret_epc;
    // Return privilege from mstatus.MPP.
    trap_pkg::priv_t   ret_pp;
    // Trap vector base from mtvec.
    logic [31:2]       tvec;
    // Per-interrupt enables from mie.
    logic [31:0]       irq_mie;

    // Dispatch side.
    modport dispatch (output ex_irq, ex_trap, ex_cause, ex_epc, ex_pp, ret, input ret_pp);

    // CSR file side.
    modport csrs (
        output ret_epc, ret_pp, tvec, irq_mie,
        input  ex_irq, ex_trap, ex_cause, ex_epc, ex_pp, ret
    );

    // Interrupt prioritizer only needs the enables.
    modport irq (input irq_mie);

endinterface

// ==== rtl/csr_file.sv ====
// Machine-mode CSR storage with combinational read and trap, MRET and write updates.
`timescale 1ns/1ns

module csr_file #(
    // Value of mhartid.
    parameter logic [31:0] hartid = 32'h0000_0000
) (
    input  logic                         clk,
    input  logic                         rst,
    // CSR access port.
    input  logic                         csr_we,
    input  trap_pkg::csr_addr_t          csr_addr,
    input  logic [trap_pkg::xlen-1:0]    csr_wdata,
    output logic [trap_pkg::xlen-1:0]    csr_rdata,
    output logic                         csr_exists,
    output logic                         csr_rdonly,
    // Latched interrupt lines, unmasked.
    input  logic [31:0]                  irq_pending,
    // Trap entry and return.
    trap_if.csrs                         bus,
    // Global interrupt enable.
    output logic                         status_mie
);

    // mstatus fields.
    logic                      st_mie;
    logic                      st_mpie;
    trap_pkg::priv_t           st_mpp;
    // mcause fields.
    logic                      mcause_int;
    trap_pkg::cause_t          mcause_code;
    // Plain registers.
    logic [31:0]               mie_reg;
    logic [31:2]               mtvec_reg;
    logic [31:0]               mscratch_reg;
    logic [31:1]               mepc_reg;
    // Composed read words.
    trap_pkg::csr_word_u       mstatus_word;
    trap_pkg::csr_word_u       mcause_word;
    logic [31:0]               mip_word;
    // Write data, decoded per target.
    trap_pkg::csr_word_u       wr_word;

    assign wr_word.raw = csr_wdata;

    // Pending lines visible only where enabled.
    assign mip_word = irq_pending & mie_reg;

    // Build mstatus and mcause from their fields.
    always_comb begin
        mstatus_word             = '0;
        mstatus_word.status.mie  = st_mie;
        mstatus_word.status.mpie = st_mpie;
        mstatus_word.status.mpp  = st_mpp;
        mcause_word              = '0;
        mcause_word.cause.irq    = mcause_int;
        mcause_word.cause.code   = mcause_code;
    end

    // Values consumed by the dispatch and prioritizer.
    assign bus.ret_epc = mepc_reg;
    assign bus.ret_pp  = st_mpp;
    assign bus.tvec    = mtvec_reg;
    assign bus.irq_mie = mie_reg;
    assign status_mie  = st_mie;

    // Read mux, valid in the same cycle as the address.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            trap_pkg::csr_mstatus: csr_rdata = mstatus_word.raw;
            trap_pkg::csr_misa: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::misa_value;
            end
            // Delegation, mstatush and mtval read as zero.
            trap_pkg::csr_medeleg,
            trap_pkg::csr_mideleg,
            trap_pkg::csr_mstatush,
            trap_pkg::csr_mtval: csr_rdata = '0;
            trap_pkg::csr_mie:      csr_rdata = mie_reg;
            trap_pkg::csr_mtvec:    csr_rdata = {mtvec_reg, 2'b00};
            trap_pkg::csr_mscratch: csr_rdata = mscratch_reg;
            trap_pkg::csr_mepc:     csr_rdata = {mepc_reg, 1'b0};
            trap_pkg::csr_mcause:   csr_rdata = mcause_word.raw;
            trap_pkg::csr_mip:      csr_rdata = mip_word;
            // Identity registers.
            trap_pkg::csr_mvendorid,
            trap_pkg::csr_mconfigptr: csr_rdonly = 1'b1;
            trap_pkg::csr_marchid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::marchid_value;
            end
            trap_pkg::csr_mimpid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::mimpid_value;
            end
            trap_pkg::csr_mhartid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            default: csr_exists = 1'b0;
        endcase
    end

    // Entry first, then MRET, then software write.
    always_ff @(posedge clk) begin
        if (rst) begin
            st_mie       <= 1'b0;
            st_mpie      <= 1'b0;
            st_mpp       <= trap_pkg::priv_m;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
            mie_reg      <= '0;
            mtvec_reg    <= '0;
            mscratch_reg <= '0;
            mepc_reg     <= '0;
        end else if (bus.ex_irq || bus.ex_trap) begin
            // Stack the interrupt enable and record the trap.
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            st_mpp      <= bus.ex_pp;
            mepc_reg    <= bus.ex_epc;
            mcause_int  <= bus.ex_irq;
            mcause_code <= bus.ex_cause;
        end else if (bus.ret) begin
            // Pop the interrupt enable.
            st_mie <= st_mpie;
        end else if (csr_we) begin
            // Read-only and unknown addresses fall through.
            case (csr_addr)
                trap_pkg::csr_mstatus: begin
                    st_mie  <= wr_word.status.mie;
                    st_mpie <= wr_word.status.mpie;
                    // Only M and U exist.
                    st_mpp  <= (wr_word.status.mpp != trap_pkg::priv_u) ?
                               trap_pkg::priv_m : trap_pkg::priv_u;
                end
                trap_pkg::csr_mie:      mie_reg      <= csr_wdata;
                trap_pkg::csr_mtvec:    mtvec_reg    <= csr_wdata[31:2];
                trap_pkg::csr_mscratch: mscratch_reg <= csr_wdata;
                trap_pkg::csr_mepc:     mepc_reg     <= csr_wdata[31:1];
                trap_pkg::csr_mcause: begin
                    mcause_int  <= wr_word.cause.irq;
                    mcause_code <= wr_word.cause.code;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/irq_prioritizer.sv ====
// Latches the external interrupt lines, masks them with mie and picks the lowest pending one.
`timescale 1ns/1ns

module irq_prioritizer #(
    // Cycles mstatus.MIE must be set before interrupts are taken.
    parameter int mie_delay = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    // External interrupt lines.
    input  logic [trap_pkg::irq_last:trap_pkg::irq_first]   irq,
    // Global enable from mstatus.
    input  logic                                            status_mie,
    // Per-interrupt enables.
    trap_if.irq                                             bus,
    // Latched lines as a full pending word.
    output logic [31:0]                                     irq_pending,
    // An enabled interrupt may be taken.
    output logic                                            irq_valid,
    // Number of the chosen interrupt.
    output trap_pkg::cause_t                                irq_cause
);

    // Lines after one register stage.
    logic [trap_pkg::irq_last:trap_pkg::irq_first] irq_q;
    // Pending and enabled.
    logic [31:0]                                   irq_masked;
    // History of mstatus.MIE.
    logic [mie_delay-1:0]                          mie_hist;
    // MIE has been stable long enough.
    logic                                          irq_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= '0;
        end else begin
            irq_q <= irq;
        end
    end

    // Lines below irq_first are never pending.
    assign irq_pending = {irq_q, {trap_pkg::irq_first{1'b0}}};
    assign irq_masked  = irq_pending & bus.irq_mie;

    // Lowest index wins, so scan downwards.
    always_comb begin
        irq_cause = '0;
        for (int i = trap_pkg::irq_last; i >= trap_pkg::irq_first; i--) begin
            if (irq_masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    // Shift in MIE every cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist    <= mie_hist << 1;
            mie_hist[0] <= status_mie;
        end
    end

    // Drops at once when MIE is cleared.
    assign irq_en    = (&mie_hist) && status_mie;
    assign irq_valid = (|irq_masked) && irq_en;

endmodule

// ==== rtl/trap_dispatch.sv ====
// Chooses between interrupt and trap at retire, issues MRET and tracks the privilege mode.
`timescale 1ns/1ns

module trap_dispatch (
    input  logic               clk,
    input  logic               rst,
    // Instruction retiring from MEM.
    input  logic               retire_valid,
    input  logic [31:1]        retire_pc,
    // Qualified synchronous trap.
    input  logic               trap_req,
    input  trap_pkg::cause_t   trap_cause,
    // MRET retiring.
    input  logic               mret,
    // From the prioritizer.
    input  logic               irq_valid,
    input  trap_pkg::cause_t   irq_cause,
    // To the CSR file.
    trap_if.dispatch           bus,
    // Redirect to the trap vector.
    output logic               exception,
    // Current privilege mode.
    output trap_pkg::priv_t    cur_priv
);

    // Interrupt accepted this cycle.
    logic take_irq;
    // Trap accepted this cycle.
    logic take_trap;

    // Interrupts need a retiring instruction to attach to.
    assign take_irq  = irq_valid && retire_valid;
    // Trap loses to an interrupt in the same cycle.
    assign take_trap = trap_req && !take_irq;
    assign exception = take_irq || take_trap;

    always_comb begin
        bus.ex_irq   = take_irq;
        bus.ex_trap  = take_trap;
        bus.ex_cause = take_irq ? irq_cause : trap_cause;
        bus.ex_epc   = retire_pc;
        bus.ex_pp    = cur_priv;
        // Entry overrides MRET.
        bus.ret      = mret && !exception;
    end

    // Entry goes to M, MRET to the saved mode.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_priv <= trap_pkg::priv_m;
        end else if (exception) begin
            cur_priv <= trap_pkg::priv_m;
        end else if (bus.ret) begin
            cur_priv <= bus.ret_pp;
        end
    end

endmodule

// ==== rtl/trap_unit.sv ====
// Top level of the machine-mode trap and CSR unit, fed by instructions retiring from MEM.
`timescale 1ns/1ns

module trap_unit #(
    // Value of mhartid.
    parameter logic [31:0] hartid    = 32'h0000_0000,
    // Cycles of stable MIE before interrupts are taken.
    parameter int          mie_delay = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [trap_pkg::irq_last:trap_pkg::irq_first]   irq,
    input  logic                                            retire_valid,
    input  logic [31:1]                                     retire_pc,
    input  logic                                            trap_req,
    input  trap_pkg::cause_t                                trap_cause,
    input  logic                                            mret,
    input  logic                                            csr_we,
    input  trap_pkg::csr_addr_t                             csr_addr,
    input  logic [31:0]                                     csr_wdata,
    output logic                                            exception,
    output logic [31:0]                                     trap_vector,
    output logic [31:0]                                     ret_target,
    output trap_pkg::priv_t                                 cur_priv,
    output logic [31:0]                                     csr_rdata,
    output logic                                            csr_exists,
    output logic                                            csr_rdonly
);

    // Latched lines before masking.
    logic [31:0]       irq_pending;
    logic              irq_valid;
    trap_pkg::cause_t  irq_cause;
    // mstatus.MIE.
    logic              status_mie;

    trap_if trap_bus ();

    // Direct mode only, vector is the aligned base.
    assign trap_vector = {trap_bus.tvec, 2'b00};
    assign ret_target  = {trap_bus.ret_epc, 1'b0};

    csr_file #(.hartid(hartid)) u_csr (
        .clk, .rst,
        .csr_we, .csr_addr, .csr_wdata,
        .csr_rdata, .csr_exists, .csr_rdonly,
        .irq_pending,
        .bus (trap_bus),
        .status_mie
    );

    irq_prioritizer #(.mie_delay(mie_delay)) u_irq (
        .clk, .rst, .irq, .status_mie,
        .bus (trap_bus),
        .irq_pending, .irq_valid, .irq_cause
    );

    trap_dispatch u_dispatch (
        .clk, .rst,
        .retire_valid, .retire_pc,
        .trap_req, .trap_cause, .mret,
        .irq_valid, .irq_cause,
        .bus (trap_bus),
        .exception, .cur_priv
    );

endmodule

// ==== tb/tb_trap_unit.sv ====
// Self-checking testbench that run_sim.sh compiles with the file list and runs against trap_unit.
`timescale 1ns/1ns

module tb_trap_unit;

    localparam logic [31:0] hart_id        = 32'h5;
    localparam int          mie_delay      = 2;
    // Stimulus length estimate with margin for the run limit.
    localparam int          test_cycles    = 800;
    localparam int          timeout_cycles = test_cycles * 5 / 2;

    // Registers probed for constants and ignored writes.
    localparam trap_pkg::csr_addr_t probe_addrs [14] = '{
        trap_pkg::csr_mstatus, trap_pkg::csr_misa, trap_pkg::csr_medeleg,
        trap_pkg::csr_mideleg, trap_pkg::csr_mstatush, trap_pkg::csr_mtval,
        trap_pkg::csr_mip, trap_pkg::csr_mvendorid, trap_pkg::csr_marchid,
        trap_pkg::csr_mimpid, trap_pkg::csr_mhartid, trap_pkg::csr_mconfigptr,
        12'h7c0, 12'h000
    };
    // Plain writable registers.
    localparam trap_pkg::csr_addr_t rw_addrs [5] = '{
        trap_pkg::csr_mscratch, trap_pkg::csr_mie, trap_pkg::csr_mtvec,
        trap_pkg::csr_mepc, trap_pkg::csr_mcause
    };

    logic                 clk;
    logic                 rst;
    logic [31:16]         irq;
    logic                 retire_valid;
    logic [31:1]          retire_pc;
    logic                 trap_req;
    trap_pkg::cause_t     trap_cause;
    logic                 mret;
    logic                 csr_we;
    trap_pkg::csr_addr_t  csr_addr;
    logic [31:0]          csr_wdata;
    logic                 exception;
    logic [31:0]          trap_vector;
    logic [31:0]          ret_target;
    trap_pkg::priv_t      cur_priv;
    logic [31:0]          csr_rdata;
    logic                 csr_exists;
    logic                 csr_rdonly;

    // Reference model of the CSR state.
    logic                 m_mie;
    logic                 m_mpie;
    trap_pkg::priv_t      m_mpp;
    logic [31:0]          m_mie_reg;
    logic [31:0]          m_mtvec;
    logic [31:0]          m_mscratch;
    logic [31:0]          m_mepc;
    logic [31:0]          m_mcause;
    trap_pkg::priv_t      m_priv;
    logic [31:16]         m_irq_q;
    // Edges in a row with MIE set.
    int                   m_mie_run;

    int errors = 0;
    int checks = 0;
    int cycle  = 0;

    trap_unit #(.hartid(hart_id), .mie_delay(mie_delay)) dut (
        .clk, .rst, .irq, .retire_valid, .retire_pc,
        .trap_req, .trap_cause, .mret,
        .csr_we, .csr_addr, .csr_wdata,
        .exception, .trap_vector, .ret_target, .cur_priv,
        .csr_rdata, .csr_exists, .csr_rdonly
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("FAIL %0t ns %s expected %h got %h", $time, name, expv, actv);
        errors++;
    endtask

    // First set line counting up from bit 0.
    function automatic trap_pkg::cause_t lowest_index(input logic [31:0] lines);
        trap_pkg::cause_t idx;
        logic             found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (!found && lines[i]) begin
                idx   = trap_pkg::cause_t'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    // Expected read port response for one address.
    task automatic model_read(input trap_pkg::csr_addr_t addr, input logic [31:0] pending,
                              output logic [31:0] data, output logic exists,
                              output logic rdonly);
        trap_pkg::csr_word_u w;
        w             = '0;
        w.status.mie  = m_mie;
        w.status.mpie = m_mpie;
        w.status.mpp  = m_mpp;
        data   = '0;
        exists = 1'b1;
        rdonly = 1'b0;
        case (addr)
            trap_pkg::csr_mstatus:  data = w.raw;
            trap_pkg::csr_mie:      data = m_mie_reg;
            trap_pkg::csr_mtvec:    data = m_mtvec;
            trap_pkg::csr_mscratch: data = m_mscratch;
            trap_pkg::csr_mepc:     data = m_mepc;
            trap_pkg::csr_mcause:   data = m_mcause;
            trap_pkg::csr_mip:      data = pending & m_mie_reg;
            trap_pkg::csr_medeleg, trap_pkg::csr_mideleg,
            trap_pkg::csr_mstatush, trap_pkg::csr_mtval: data = '0;
            trap_pkg::csr_misa: begin
                rdonly = 1'b1;
                data   = 32'h4000_1105;
            end
            trap_pkg::csr_marchid: begin
                rdonly = 1'b1;
                data   = 32'd37;
            end
            trap_pkg::csr_mimpid: begin
                rdonly = 1'b1;
                data   = 32'h0000_0200;
            end
            trap_pkg::csr_mhartid: begin
                rdonly = 1'b1;
                data   = hart_id;
            end
            trap_pkg::csr_mvendorid, trap_pkg::csr_mconfigptr: rdonly = 1'b1;
            default: exists = 1'b0;
        endcase
    endtask

    // Compare against the model on the pre-edge values, then advance the model.
    always @(posedge clk) begin : check_and_update
        logic [31:0]         pending;
        logic [31:0]         masked;
        logic                irq_on;
        logic                take_irq;
        logic                exp_exc;
        logic [31:0]         exp_data;
        logic                exp_exists;
        logic                exp_rdonly;
        trap_pkg::csr_word_u w;

        pending  = {m_irq_q, 16'h0000};
        masked   = pending & m_mie_reg;
        irq_on   = m_mie && (m_mie_run >= mie_delay);
        take_irq = retire_valid && (masked != '0) && irq_on;
        exp_exc  = take_irq || trap_req;
        model_read(csr_addr, pending, exp_data, exp_exists, exp_rdonly);

        if (!rst) begin
            checks = checks + 7;
            assert (exception == exp_exc)
                else report_mismatch("exception", 32'(exp_exc), 32'(exception));
            assert (trap_vector == m_mtvec)
                else report_mismatch("trap_vector", m_mtvec, trap_vector);
            assert (ret_target == m_mepc)
                else report_mismatch("ret_target", m_mepc, ret_target);
            assert (cur_priv == m_priv)
                else report_mismatch("cur_priv", 32'(m_priv), 32'(cur_priv));
            assert (csr_rdata == exp_data)
                else report_mismatch("csr_rdata", exp_data, csr_rdata);
            assert (csr_exists == exp_exists)
                else report_mismatch("csr_exists", 32'(exp_exists), 32'(csr_exists));
            assert (csr_rdonly == exp_rdonly)
                else report_mismatch("csr_rdonly", 32'(exp_rdonly), 32'(csr_rdonly));
        end

        if (rst) begin
            m_mie      = 1'b0;
            m_mpie     = 1'b0;
            m_mpp      = trap_pkg::priv_m;
            m_mie_reg  = '0;
            m_mtvec    = '0;
            m_mscratch = '0;
            m_mepc     = '0;
            m_mcause   = '0;
            m_priv     = trap_pkg::priv_m;
            m_irq_q    = '0;
            m_mie_run  = 0;
        end else begin
            // Uses MIE from before this edge.
            m_mie_run = m_mie ? m_mie_run + 1 : 0;
            m_irq_q   = irq;
            if (exp_exc) begin
                m_mpie       = m_mie;
                m_mie        = 1'b0;
                m_mpp        = m_priv;
                m_mepc       = {retire_pc, 1'b0};
                w            = '0;
                w.cause.irq  = take_irq;
                w.cause.code = take_irq ? lowest_index(masked) : trap_cause;
                m_mcause     = w.raw;
                m_priv       = trap_pkg::priv_m;
            end else if (mret) begin
                m_mie  = m_mpie;
                m_priv = m_mpp;
            end else if (csr_we) begin
                w.raw = csr_wdata;
                case (csr_addr)
                    trap_pkg::csr_mstatus: begin
                        m_mie  = w.status.mie;
                        m_mpie = w.status.mpie;
                        m_mpp  = (w.status.mpp == trap_pkg::priv_u) ?
                                 trap_pkg::priv_u : trap_pkg::priv_m;
                    end
                    trap_pkg::csr_mie:      m_mie_reg  = csr_wdata;
                    trap_pkg::csr_mtvec:    m_mtvec    = csr_wdata & 32'hffff_fffc;
                    trap_pkg::csr_mscratch: m_mscratch = csr_wdata;
                    trap_pkg::csr_mepc:     m_mepc     = csr_wdata & 32'hffff_fffe;
                    trap_pkg::csr_mcause:   m_mcause   = csr_wdata & 32'h8000_001f;
                    default: ;
                endcase
            end
        end
    end

    // Run limit.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Run stopped at cycle %0d before the tests finished", cycle);
            $display("checks %0d, errors %0d", checks, errors);
            $display("tests failed");
            $finish;
        end
    end

    // Each task starts on a falling edge and returns on the next one.
    task automatic write_csr(input trap_pkg::csr_addr_t addr, input logic [31:0] data);
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    task automatic read_csr(input trap_pkg::csr_addr_t addr);
        csr_addr = addr;
        @(negedge clk);
    endtask

    task automatic raise_trap(input trap_pkg::cause_t cause, input logic [31:1] pc);
        trap_req     = 1'b1;
        trap_cause   = cause;
        retire_valid = 1'b1;
        retire_pc    = pc;
        @(negedge clk);
        trap_req     = 1'b0;
        retire_valid = 1'b0;
    endtask

    task automatic retire(input logic [31:1] pc);
        retire_valid = 1'b1;
        retire_pc    = pc;
        @(negedge clk);
        retire_valid = 1'b0;
    endtask

    task automatic pulse_mret();
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        void'($urandom(32'h410f94d9));
        rst          = 1'b1;
        irq          = '0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        trap_req     = 1'b0;
        trap_cause   = '0;
        mret         = 1'b0;
        csr_we       = 1'b0;
        csr_addr     = trap_pkg::csr_mstatus;
        csr_wdata    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state, identity registers, unknown addresses.
        foreach (probe_addrs[i]) read_csr(probe_addrs[i]);

        // Random write and read back.
        repeat (20) begin
            foreach (rw_addrs[i]) begin
                write_csr(rw_addrs[i], $urandom);
                read_csr(rw_addrs[i]);
            end
        end
        // Writes that must be dropped.
        foreach (probe_addrs[i]) begin
            if (probe_addrs[i] != trap_pkg::csr_mstatus) begin
                write_csr(probe_addrs[i], $urandom);
                read_csr(probe_addrs[i]);
            end
        end

        // Synchronous traps from random status.
        write_csr(trap_pkg::csr_mtvec, $urandom);
        repeat (12) begin
            write_csr(trap_pkg::csr_mstatus, $urandom);
            r = $urandom;
            s = $urandom;
            raise_trap(r[4:0], s[31:1]);
            read_csr(trap_pkg::csr_mcause);
            read_csr(trap_pkg::csr_mepc);
            read_csr(trap_pkg::csr_mstatus);
        end

        // MRET into U mode, then a trap back to M.
        write_csr(trap_pkg::csr_mepc, $urandom);
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0080);
        pulse_mret();
        read_csr(trap_pkg::csr_mstatus);
        r = $urandom;
        raise_trap(r[4:0], r[31:1]);
        read_csr(trap_pkg::csr_mstatus);
        repeat (10) begin
            write_csr(trap_pkg::csr_mstatus, $urandom);
            pulse_mret();
            read_csr(trap_pkg::csr_mstatus);
        end

        // Interrupt right after MIE is set is held off.
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0000);
        irq = 16'ha5a0;
        write_csr(trap_pkg::csr_mie, 32'hffff_0000);
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0008);
        retire(31'h100);
        retire(31'h102);
        repeat (3) read_csr(trap_pkg::csr_mip);
        retire(31'h104);
        read_csr(trap_pkg::csr_mcause);
        read_csr(trap_pkg::csr_mstatus);

        // Random lines, masks and status with an occasional trap in the same cycle.
        repeat (25) begin
            r   = $urandom;
            irq = r[15:0];
            write_csr(trap_pkg::csr_mie, $urandom);
            write_csr(trap_pkg::csr_mstatus, $urandom);
            repeat (mie_delay) read_csr(trap_pkg::csr_mip);
            r = $urandom;
            s = $urandom;
            if (r[0]) begin
                raise_trap(r[5:1], s[31:1]);
            end else begin
                retire(s[31:1]);
            end
            read_csr(trap_pkg::csr_mcause);
        end

        // All raised lines masked by mie.
        irq = 16'hffff;
        write_csr(trap_pkg::csr_mie, 32'h0000_ffff);
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0008);
        repeat (3) read_csr(trap_pkg::csr_mip);
        retire(31'h200);
        // MIE clear with lines enabled.
        write_csr(trap_pkg::csr_mie, 32'hffff_0000);
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0000);
        retire(31'h204);
        repeat (3) read_csr(trap_pkg::csr_mip);
        irq = '0;
        read_csr(trap_pkg::csr_mcause);
        @(negedge clk);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== trap_unit.f ====
rtl/trap_pkg.sv
rtl/trap_if.sv
rtl/csr_file.sv
rtl/irq_prioritizer.sv
rtl/trap_dispatch.sv
rtl/trap_unit.sv
tb/tb_trap_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_trap_unit -f trap_unit.f &&
./obj_dir/Vtb_trap_unit | tee /dev/stderr | grep "all tests passed" > /dev/null &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }
